//--- compile.f
cnn_pkg.sv
cnn_weight_bank.sv
cnn_kernel.sv
cnn_channel_sum.sv
cnn_core.sv
cnn_core_assertions.sv
tb_cnn_core.sv

//--- tb_cnn_core.sv
module tb_cnn_core import cnn_pkg::*; ();

    localparam int KX = DEF_KX;
    localparam int KY = DEF_KY;
    localparam int I_F_BW = DEF_I_F_BW;
    localparam int W_BW = DEF_W_BW;
    localparam int B_BW = DEF_B_BW;
    localparam int O_F_BW = DEF_O_F_BW;
    localparam int N_TAP = KX * KY;
    localparam int N_WGT = CI * N_TAP;
    localparam int IDX_BW = $clog2(N_WGT);
    localparam int CLK_PERIOD = 40;

    localparam int MODE_SMALL = 0;  // Small pixels and weights
    localparam int MODE_NEG = 1;    // Negative weights and bias
    localparam int MODE_BIG = 2;    // Full pixels, largest weight

    // ====================
    // Cycle budget
    // ====================
    localparam int N_LAT = 4;
    localparam int N_ARITH = 12;
    localparam int N_CLAMP = 4;
    localparam int BURST_LEN = 8;
    localparam int N_TESTS = 6;
    localparam int LOAD_CYC = N_WGT + 1;
    localparam int SINGLE_CYC = 7;  // Send, pipeline, count
    localparam int STIM_CYC = 2 + 4 + N_TESTS + 6 * LOAD_CYC
                            + (N_LAT + N_ARITH + 2 * N_CLAMP) * SINGLE_CYC
                            + 2 * (BURST_LEN + 6);
    localparam int WATCHDOG_CYC = STIM_CYC + 20;

    logic clk;
    logic reset_n;
    logic i_wgt_we;
    logic [IDX_BW-1:0] i_wgt_idx;
    logic [W_BW-1:0] i_wgt_data;
    logic i_in_valid;
    logic [N_TAP*I_F_BW-1:0] i_in_fmap_ch0;
    logic [N_TAP*I_F_BW-1:0] i_in_fmap_ch1;
    logic signed [B_BW-1:0] i_bias;
    logic o_ot_valid;
    logic [O_F_BW-1:0] o_ot_fmap;

    logic [31:0] lfsr_state = 32'h7aa3;
    int sent_count = 0;
    int out_count;
    int fails_before = 0;
    int n_good = 0;
    int n_bad = 0;

    cnn_core #(
        .KX(KX), .KY(KY), .I_F_BW(I_F_BW), .W_BW(W_BW), .B_BW(B_BW), .O_F_BW(O_F_BW)
    ) uut (
        .clk(clk), .reset_n(reset_n), .i_wgt_we(i_wgt_we), .i_wgt_idx(i_wgt_idx),
        .i_wgt_data(i_wgt_data), .i_in_valid(i_in_valid), .i_in_fmap_ch0(i_in_fmap_ch0),
        .i_in_fmap_ch1(i_in_fmap_ch1), .i_bias(i_bias), .o_ot_valid(o_ot_valid),
        .o_ot_fmap(o_ot_fmap)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_count <= 0;
        end else if (o_ot_valid) begin
            out_count <= out_count + 1;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [W_BW-1:0] pick_weight(input int mode);
        case (mode)
            MODE_SMALL: return W_BW'(int'(rand_bits(3)) - 3);   // -3 to 4
            MODE_NEG:   return W_BW'(-1 - int'(rand_bits(2)));  // -1 to -4
            default:    return W_BW'((1 << (W_BW - 1)) - 1);
        endcase
    endfunction

    function automatic logic [I_F_BW-1:0] pick_pixel(input int mode);
        case (mode)
            MODE_SMALL: return I_F_BW'(rand_bits(4));
            MODE_NEG:   return I_F_BW'(rand_bits(I_F_BW));
            default:    return '1;
        endcase
    endfunction

    function automatic logic signed [B_BW-1:0] pick_bias(input int mode);
        case (mode)
            MODE_NEG: return {1'b1, (B_BW-1)'(rand_bits(B_BW - 1))};
            default:  return B_BW'(rand_bits(B_BW));
        endcase
    endfunction

    // ====================
    // Stimulus tasks
    // ====================

    task automatic load_weights(input int mode);
        for (int i = 0; i < N_WGT; i++) begin
            @(posedge clk);
            i_wgt_we   <= 1'b1;
            i_wgt_idx  <= IDX_BW'(i);
            i_wgt_data <= pick_weight(mode);
        end
        @(posedge clk);
        i_wgt_we <= 1'b0;
    endtask

    task automatic send_window(input int mode);
        logic [N_TAP*I_F_BW-1:0] f0;
        logic [N_TAP*I_F_BW-1:0] f1;
        for (int t = 0; t < N_TAP; t++) begin
            f0[t*I_F_BW +: I_F_BW] = pick_pixel(mode);
            f1[t*I_F_BW +: I_F_BW] = pick_pixel(mode);
        end
        @(posedge clk);
        i_in_valid    <= 1'b1;
        i_in_fmap_ch0 <= f0;
        i_in_fmap_ch1 <= f1;
        i_bias        <= pick_bias(mode);
        sent_count++;
    endtask

    // Wait until every window sent has come out
    task automatic drain();
        @(posedge clk);
        i_in_valid <= 1'b0;
        while (out_count != sent_count) begin
            @(posedge clk);
        end
    endtask

    task automatic single_window(input int mode);
        send_window(mode);
        drain();
    endtask

    task automatic finish_test(input string name);
        int new_fails;
        @(negedge clk);  // Let the last edge's checks settle
        new_fails = uut.u_chk.fail_count - fails_before;
        if (new_fails != 0) begin
            $display("error %s: expected 0 assertion failures, actual %0d", name, new_fails);
            n_bad++;
        end else begin
            $display("%s: ok, %0d outputs so far", name, out_count);
            n_good++;
        end
        fails_before = uut.u_chk.fail_count;
    endtask

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset_n <= 1'b0;  // Reset edge lands after every process is waiting
        i_wgt_we = 1'b0;
        i_wgt_idx = '0;
        i_wgt_data = '0;
        i_in_valid = 1'b0;
        i_in_fmap_ch0 = '0;
        i_in_fmap_ch1 = '0;
        i_bias = '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) @(posedge clk);
        finish_test("reset");

        load_weights(MODE_SMALL);
        repeat (N_LAT) single_window(MODE_SMALL);
        finish_test("latency");
        load_weights(MODE_SMALL);
        repeat (N_ARITH) single_window(MODE_SMALL);
        finish_test("arithmetic");
        load_weights(MODE_NEG);
        repeat (N_CLAMP) single_window(MODE_NEG);
        finish_test("relu");
        load_weights(MODE_BIG);
        repeat (N_CLAMP) single_window(MODE_BIG);
        finish_test("saturation");

        // Back to back bursts, new weights in between
        load_weights(MODE_SMALL);
        repeat (BURST_LEN) send_window(MODE_SMALL);
        drain();
        load_weights(MODE_SMALL);
        repeat (BURST_LEN) send_window(MODE_SMALL);
        drain();
        finish_test("streaming");

        $display("%0d tests ok, %0d with errors, %0d assertion failures in all",
                 n_good, n_bad, uut.u_chk.fail_count);
        if (n_bad == 0 && uut.u_chk.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- cnn_core_assertions.sv
module cnn_core_assertions import cnn_pkg::*; #(
    parameter int KX     = DEF_KX,
    parameter int KY     = DEF_KY,
    parameter int I_F_BW = DEF_I_F_BW,
    parameter int W_BW   = DEF_W_BW,
    parameter int B_BW   = DEF_B_BW,
    parameter int O_F_BW = DEF_O_F_BW
) (
    input logic                        clk,
    input logic                        reset_n,
    input logic                        i_wgt_we,
    input logic [$clog2(CI*KX*KY)-1:0] i_wgt_idx,
    input logic [W_BW-1:0]             i_wgt_data,
    input logic                        i_in_valid,
    input logic [KX*KY*I_F_BW-1:0]     i_in_fmap_ch0,
    input logic [KX*KY*I_F_BW-1:0]     i_in_fmap_ch1,
    input logic signed [B_BW-1:0]      i_bias,
    input logic                        o_ot_valid,
    input logic [O_F_BW-1:0]           o_ot_fmap
);

    localparam int N_TAP = KX * KY;
    localparam int N_WGT = CI * N_TAP;
    localparam longint O_MAX = (longint'(1) << O_F_BW) - 1;

    int fail_count = 0;
    logic signed [W_BW-1:0] shadow [N_WGT];  // Copy of the bank, from the load port
    logic seen_out;
    longint total;
    logic [O_F_BW-1:0] expected;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N_WGT; i++) begin
                shadow[i] <= '0;
            end
            seen_out <= 1'b0;
        end else begin
            if (i_wgt_we && (i_wgt_idx < N_WGT)) begin
                shadow[i_wgt_idx] <= i_wgt_data;
            end
            if (o_ot_valid) begin
                seen_out <= 1'b1;
            end
        end
    end

    // Reference output for the window on the input port
    always_comb begin
        total = longint'(i_bias);
        for (int t = 0; t < N_TAP; t++) begin
            total += longint'(i_in_fmap_ch0[t*I_F_BW +: I_F_BW]) * longint'(shadow[t]);
            total += longint'(i_in_fmap_ch1[t*I_F_BW +: I_F_BW]) * longint'(shadow[N_TAP + t]);
        end
        if (total < 0) begin
            expected = '0;
        end else if (total > O_MAX) begin
            expected = '1;
        end else begin
            expected = total[O_F_BW-1:0];
        end
    end

    // ====================
    // Properties
    // ====================

    a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !o_ot_valid && o_ot_fmap == '0)
        else begin
            $error("output active during reset");
            fail_count++;
        end

    a_idle_zero: assert property (@(posedge clk) disable iff (!reset_n)
        (!seen_out && !o_ot_valid) |-> o_ot_fmap == '0)
        else begin
            $error("output pixel not zero before the first result");
            fail_count++;
        end

    a_latency: assert property (@(posedge clk) disable iff (!reset_n)
        i_in_valid |-> ##3 o_ot_valid)
        else begin
            $error("no output valid three cycles after an input window");
            fail_count++;
        end

    a_no_stray: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid |-> $past(i_in_valid, 3))
        else begin
            $error("output valid without an input window three cycles before");
            fail_count++;
        end

    a_value: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid |-> o_ot_fmap == $past(expected, 3))
        else begin
            $error("output pixel differs from the reference model");
            fail_count++;
        end

endmodule

bind cnn_core cnn_core_assertions #(
    .KX(KX), .KY(KY), .I_F_BW(I_F_BW), .W_BW(W_BW), .B_BW(B_BW), .O_F_BW(O_F_BW)
) u_chk (
    .clk(clk), .reset_n(reset_n), .i_wgt_we(i_wgt_we), .i_wgt_idx(i_wgt_idx),
    .i_wgt_data(i_wgt_data), .i_in_valid(i_in_valid), .i_in_fmap_ch0(i_in_fmap_ch0),
    .i_in_fmap_ch1(i_in_fmap_ch1), .i_bias(i_bias), .o_ot_valid(o_ot_valid),
    .o_ot_fmap(o_ot_fmap)
);

//--- cnn_core.sv
module cnn_core import cnn_pkg::*; #(
    parameter int KX     = DEF_KX,
    parameter int KY     = DEF_KY,
    parameter int I_F_BW = DEF_I_F_BW,
    parameter int W_BW   = DEF_W_BW,
    parameter int B_BW   = DEF_B_BW,
    parameter int O_F_BW = DEF_O_F_BW
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_wgt_we,
    input  logic [$clog2(CI*KX*KY)-1:0]   i_wgt_idx,
    input  logic [W_BW-1:0]               i_wgt_data,
    input  logic                          i_in_valid,
    input  logic [KX*KY*I_F_BW-1:0]       i_in_fmap_ch0,
    input  logic [KX*KY*I_F_BW-1:0]       i_in_fmap_ch1,
    input  logic signed [B_BW-1:0]        i_bias,
    output logic                          o_ot_valid,
    output logic [O_F_BW-1:0]             o_ot_fmap
);

    localparam int ACC_BW = acc_bw(I_F_BW, W_BW, KX, KY);

    logic [KX*KY*W_BW-1:0] weight_ch0;
    logic [KX*KY*W_BW-1:0] weight_ch1;
    logic                  kern_valid;      // Channel 1 runs in lockstep
    logic signed [ACC_BW-1:0] acc_ch0;
    logic signed [ACC_BW-1:0] acc_ch1;

    // ====================
    // Weights
    // ====================

    cnn_weight_bank #(.KX(KX), .KY(KY), .W_BW(W_BW)) u_bank (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_wgt_we     (i_wgt_we),
        .i_wgt_idx    (i_wgt_idx),
        .i_wgt_data   (i_wgt_data),
        .o_weight_ch0 (weight_ch0),
        .o_weight_ch1 (weight_ch1)
    );

    // ====================
    // Kernels
    // ====================

    cnn_kernel #(.KX(KX), .KY(KY), .I_F_BW(I_F_BW), .W_BW(W_BW)) u_kernel_ch0 (
        .clk(clk), .reset_n(reset_n), .i_cnn_weight(weight_ch0), .i_in_valid(i_in_valid),
        .i_in_fmap(i_in_fmap_ch0), .o_ot_valid(kern_valid), .o_ot_kernel_acc(acc_ch0)
    );

    cnn_kernel #(.KX(KX), .KY(KY), .I_F_BW(I_F_BW), .W_BW(W_BW)) u_kernel_ch1 (
        .clk(clk), .reset_n(reset_n), .i_cnn_weight(weight_ch1), .i_in_valid(i_in_valid),
        .i_in_fmap(i_in_fmap_ch1), .o_ot_valid(), .o_ot_kernel_acc(acc_ch1)
    );

    // Bias follows the window through both kernel stages
    logic signed [B_BW-1:0] r_bias_d1;
    logic signed [B_BW-1:0] r_bias_d2;

    always_ff @(posedge clk) begin
        r_bias_d1 <= i_bias;
        r_bias_d2 <= r_bias_d1;
    end

    cnn_channel_sum #(
        .KX(KX), .KY(KY), .I_F_BW(I_F_BW), .W_BW(W_BW), .B_BW(B_BW), .O_F_BW(O_F_BW)
    ) u_sum (
        .clk(clk), .reset_n(reset_n), .i_in_valid(kern_valid), .i_acc_ch0(acc_ch0),
        .i_acc_ch1(acc_ch1), .i_bias(r_bias_d2), .o_ot_valid(o_ot_valid), .o_ot_fmap(o_ot_fmap)
    );

endmodule

//--- cnn_channel_sum.sv
module cnn_channel_sum import cnn_pkg::*; #(
    parameter int KX     = DEF_KX,
    parameter int KY     = DEF_KY,
    parameter int I_F_BW = DEF_I_F_BW,
    parameter int W_BW   = DEF_W_BW,
    parameter int B_BW   = DEF_B_BW,
    parameter int O_F_BW = DEF_O_F_BW
) (
    input  logic                                              clk,
    input  logic                                              reset_n,
    input  logic                                              i_in_valid,
    input  logic signed [acc_bw(I_F_BW, W_BW, KX, KY)-1:0]    i_acc_ch0,
    input  logic signed [acc_bw(I_F_BW, W_BW, KX, KY)-1:0]    i_acc_ch1,
    input  logic signed [B_BW-1:0]                            i_bias,
    output logic                                              o_ot_valid,
    output logic [O_F_BW-1:0]                                 o_ot_fmap
);

    localparam int ACC_BW = acc_bw(I_F_BW, W_BW, KX, KY);

    // Widest operand plus two carry bits for a three-input add
    localparam int MAX_BW = (ACC_BW > B_BW) ? ACC_BW : B_BW;
    localparam int WIDE_BW = (MAX_BW > O_F_BW) ? MAX_BW : O_F_BW;
    localparam int SUM_BW = WIDE_BW + 2;

    // Largest output pixel, positive in SUM_BW
    localparam logic signed [SUM_BW-1:0] O_MAX = {{(SUM_BW-O_F_BW){1'b0}}, {O_F_BW{1'b1}}};

    // ====================
    // Add and clamp
    // ====================

    logic signed [SUM_BW-1:0] total;
    logic [O_F_BW-1:0] clamp;

    always_comb begin
        total = SUM_BW'(i_acc_ch0) + SUM_BW'(i_acc_ch1) + SUM_BW'(i_bias);
    end

    always_comb begin
        if (total[SUM_BW-1]) begin
            clamp = '0;                    // ReLU
        end else if (total > O_MAX) begin
            clamp = '1;                    // Saturate high
        end else begin
            clamp = total[O_F_BW-1:0];
        end
    end

    // ====================
    // Output register
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
            o_ot_fmap  <= '0;
        end else begin
            o_ot_valid <= i_in_valid;
            if (i_in_valid) begin
                o_ot_fmap <= clamp;        // Holds last pixel between strobes
            end
        end
    end

endmodule

//--- cnn_kernel.sv
module cnn_kernel import cnn_pkg::*; #(
    parameter int KX     = DEF_KX,
    parameter int KY     = DEF_KY,
    parameter int I_F_BW = DEF_I_F_BW,
    parameter int W_BW   = DEF_W_BW
) (
    input  logic                                              clk,
    input  logic                                              reset_n,
    input  logic [KX*KY*W_BW-1:0]                             i_cnn_weight,
    input  logic                                              i_in_valid,
    input  logic [KX*KY*I_F_BW-1:0]                           i_in_fmap,
    output logic                                              o_ot_valid,
    output logic signed [acc_bw(I_F_BW, W_BW, KX, KY)-1:0]    o_ot_kernel_acc
);

    localparam int N_TAP  = KX * KY;
    localparam int M_BW   = mul_bw(I_F_BW, W_BW);
    localparam int ACC_BW = acc_bw(I_F_BW, W_BW, KX, KY);

    // ====================
    // Valid pipeline
    // ====================

    // Bit 0 after the product stage, bit 1 after the sum stage
    logic [1:0] r_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 2'b00;
        end else begin
            r_valid <= {r_valid[0], i_in_valid};
        end
    end

    assign o_ot_valid = r_valid[1];

    // ====================
    // Stage 1 multiply
    // ====================

    // Tap t = row*KX + col for both pixel and weight
    logic signed [M_BW-1:0] mul [N_TAP];
    logic signed [M_BW-1:0] r_mul [N_TAP];

    always_comb begin
        for (int t = 0; t < N_TAP; t++) begin
            // Zero bit keeps the pixel unsigned inside a signed multiply
            mul[t] = $signed({1'b0, i_in_fmap[t*I_F_BW +: I_F_BW]})
                   * $signed(i_cnn_weight[t*W_BW +: W_BW]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int t = 0; t < N_TAP; t++) begin
                r_mul[t] <= mul[t];
            end
        end
    end

    // ====================
    // Stage 2 sum
    // ====================

    logic signed [ACC_BW-1:0] acc_sum;
    logic signed [ACC_BW-1:0] r_acc;

    // Adder tree left to synthesis
    always_comb begin
        acc_sum = '0;
        for (int t = 0; t < N_TAP; t++) begin
            acc_sum = acc_sum + r_mul[t];  // Sign extended to ACC_BW
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_acc <= '0;
        end else if (r_valid[0]) begin     // Products of this window are ready
            r_acc <= acc_sum;
        end
    end

    assign o_ot_kernel_acc = r_acc;

endmodule

//--- cnn_weight_bank.sv
module cnn_weight_bank import cnn_pkg::*; #(
    parameter int KX   = DEF_KX,
    parameter int KY   = DEF_KY,
    parameter int W_BW = DEF_W_BW
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_wgt_we,
    input  logic [$clog2(CI*KX*KY)-1:0]   i_wgt_idx,
    input  logic [W_BW-1:0]               i_wgt_data,
    output logic [KX*KY*W_BW-1:0]         o_weight_ch0,
    output logic [KX*KY*W_BW-1:0]         o_weight_ch1
);

    localparam int N_TAP = KX * KY;    // Weights per channel
    localparam int N_WGT = CI * N_TAP; // Whole bank

    // ====================
    // Storage
    // ====================

    // Channel 0 first, then channel 1, row-major inside a channel
    logic [W_BW-1:0] wgt_mem [N_WGT];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N_WGT; i++) begin
                wgt_mem[i] <= '0;
            end
        end else if (i_wgt_we && (i_wgt_idx < N_WGT)) begin  // Out of range idx dropped
            wgt_mem[i_wgt_idx] <= i_wgt_data;
        end
    end

    // ====================
    // Per-channel split
    // ====================

    // Tap t sits at bits [t*W_BW +: W_BW], same order as the window
    for (genvar t = 0; t < N_TAP; t++) begin : g_split
        assign o_weight_ch0[t*W_BW +: W_BW] = wgt_mem[t];
        assign o_weight_ch1[t*W_BW +: W_BW] = wgt_mem[N_TAP + t];
    end

endmodule

//--- cnn_pkg.sv
package cnn_pkg;

    // ====================
    // Structure
    // ====================
    localparam int CI = 2;  // Input channels, one kernel each

    // ====================
    // Default geometry
    // ====================
    localparam int DEF_KX = 5;
    localparam int DEF_KY = 5;

    // Default widths
    localparam int DEF_I_F_BW = 8;  // Feature pixel, unsigned
    localparam int DEF_W_BW   = 8;  // Weight, signed
    localparam int DEF_B_BW   = 8;  // Bias, signed
    localparam int DEF_O_F_BW = 8;  // Output pixel, unsigned

    // ====================
    // Width rules
    // ====================

    // One pixel times one weight
    function automatic int mul_bw(input int i_f_bw, input int w_bw);
        return i_f_bw + w_bw;
    endfunction

    // Kernel sum grows by log2 of the tap count
    function automatic int acc_bw(
        input int i_f_bw,
        input int w_bw,
        input int kx,
        input int ky
    );
        return mul_bw(i_f_bw, w_bw) + $clog2(kx * ky);
    endfunction

endpackage
